/* project.f */
+incdir+.
z8Pkg.sv
z8Alu.sv
z8RegFile.sv
z8Decoder.sv
z8Sequencer.sv
z8Core.sv
z8Core_asserts.sv
z8CoreTb.sv

/* z8CoreTb.sv */
`default_nettype none
`include "z8_consts.svh"

module z8CoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import z8Pkg::*;

    localparam int memSize = 1024;
    localparam int numPrograms = 6;
    localparam int instrPerProgram = 40;

    logic clk = 1'b0;
    logic rst;
    wbReqT wbReq;
    wbRspT wbRsp;
    logic [7:0] port2;

    logic [7:0] mem [memSize];
    int genPc;
    int progLen;
    int errors = 0;
    int ackWait;

    // reference machine state
    logic [7:0] refRegs [128];
    flagsT refFlags;
    logic [3:0] refRp;
    logic [7:0] refPort2;
    logic [7:0] expPort2 [$];
    logic [15:0] expLoop;

    // observed side
    int seenCount;
    logic [7:0] lastPort2;
    logic [15:0] ackAddr [2];
    logic [15:0] loopAddr;
    logic loopSeen;

    z8Core z8Core_inst (.clk, .rst, .wbReq, .wbRsp, .port2);

    always #2 clk = ~clk;

    // program memory slave with 0 to 3 extra wait cycles
    always @(posedge clk) begin
        if (rst) begin
            wbRsp <= '0;
            ackWait <= 0;
        end else if (wbRsp.ack) begin
            wbRsp.ack <= 1'b0;
        end else if (wbReq.cyc && wbReq.stb) begin
            if (ackWait == 0) begin
                wbRsp.ack <= 1'b1;
                wbRsp.dat <= mem[wbReq.adr % memSize];
                ackWait <= $urandom % 4;
            end else begin
                ackWait <= ackWait - 1;
            end
        end
    end

    // compares each port 2 change against the expected sequence
    always @(posedge clk) begin
        if (rst) begin
            lastPort2 <= '0;
            seenCount <= 0;
            loopSeen <= 1'b0;
            ackAddr[0] <= 16'hFFFF;
            ackAddr[1] <= 16'hFFFF;
        end else begin
            if (port2 != lastPort2) begin
                if (seenCount >= expPort2.size()) begin
                    $display("port2 changed to %02h after the expected sequence ended", port2);
                    errors++;
                end else if (port2 !== expPort2[seenCount]) begin
                    $display("mismatch port2 change %0d: got %02h, expected %02h",
                             seenCount, port2, expPort2[seenCount]);
                    errors++;
                end
                seenCount <= seenCount + 1;
                lastPort2 <= port2;
            end
            if (wbReq.cyc && wbRsp.ack) begin
                // jr FE refetches the address from two transfers back
                if (wbReq.adr == ackAddr[1]) begin
                    loopSeen <= 1'b1;
                    loopAddr <= wbReq.adr;
                end
                ackAddr[1] <= ackAddr[0];
                ackAddr[0] <= wbReq.adr;
            end
        end
    end

    function automatic void emit(input logic [7:0] b);
        mem[genPc] = b;
        genPc++;
    endfunction

    task automatic buildProgram();
        logic [3:0] aluOps [10] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7,
                                    4'hA, 4'hB};
        logic [15:0] target;
        for (int i = 0; i < memSize; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
        genPc = `Z8_RESET_PC;
        emit(8'h31);
        emit(8'h01);
        for (int n = 0; n < instrPerProgram; n++) begin
            case ($urandom % 8)
                0: begin
                    emit(8'h2C);
                    emit(8'($urandom));
                end
                1: begin
                    emit(8'hE6);
                    emit(8'h02);
                    emit(8'($urandom));
                end
                2: begin
                    emit({aluOps[$urandom % 10], 4'h6});
                    emit(($urandom % 2) ? 8'h02 : 8'hE2);
                    emit(8'($urandom));
                end
                3: emit(8'h2E);
                4: emit({4'hC + 4'($urandom % 4), 4'hF});
                5: begin
                    // skip over one ld r2 when taken
                    emit({4'($urandom), 4'hB});
                    emit(8'h02);
                    emit(8'h2C);
                    emit(8'($urandom));
                end
                6: begin
                    target = 16'(genPc + 5);
                    emit({4'($urandom), 4'hD});
                    emit(target[15:8]);
                    emit(target[7:0]);
                    emit(8'h2C);
                    emit(8'($urandom));
                end
                default: begin
                    // counter in r5, loop body bumps port 2
                    emit(8'h5C);
                    emit(8'(1 + $urandom % 5));
                    emit(8'h2E);
                    emit(8'h5A);
                    emit(8'hFD);
                end
            endcase
        end
        emit(8'h8B);
        emit(8'hFE);
        progLen = genPc - `Z8_RESET_PC;
    endtask

    function automatic logic [7:0] workAddr(input logic [7:0] addr);
        return (addr[7:4] == 4'hE) ? {refRp, addr[3:0]} : addr;
    endfunction

    function automatic logic [7:0] readReg(input logic [7:0] addr);
        logic [7:0] t;
        t = workAddr(addr);
        if (t < 8'h80) return refRegs[t[6:0]];
        if (t == 8'hFC) return refFlags;
        if (t == 8'hFD) return {refRp, 4'h0};
        return 8'h00;
    endfunction

    function automatic void writeReg(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] t;
        t = workAddr(addr);
        if (t < 8'h80) begin
            refRegs[t[6:0]] = data;
        end else if (t == 8'hFC) begin
            refFlags = flagsT'(data);
        end else if (t == 8'hFD) begin
            refRp = data[7:4];
        end
        if (t == 8'h02) begin
            if (data != refPort2) expPort2.push_back(data);
            refPort2 = data;
        end
    endfunction

    function automatic logic condTrue(input logic [3:0] cc);
        logic r;
        case (cc[2:0])
            3'd0: r = 1'b0;
            3'd1: r = refFlags.s ^ refFlags.v;
            3'd2: r = (refFlags.s ^ refFlags.v) | refFlags.z;
            3'd3: r = refFlags.c | refFlags.z;
            3'd4: r = refFlags.v;
            3'd5: r = refFlags.s;
            3'd6: r = refFlags.z;
            default: r = refFlags.c;
        endcase
        return r ^ cc[3];
    endfunction

    // result of one ALU op, flags updated on the side
    function automatic logic [7:0] aluStep(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
        int ci;
        int full;
        int low;
        logic [7:0] r;
        ci = (op == 4'h1 || op == 4'h3) ? int'(refFlags.c) : 0;
        r = a;
        case (op)
            4'h0, 4'h1: begin
                full = int'(a) + int'(b) + ci;
                low = int'(a & 8'h0F) + int'(b & 8'h0F) + ci;
                r = full[7:0];
                refFlags.c = full > 255;
                refFlags.h = low > 15;
                refFlags.v = (a[7] == b[7]) && (r[7] != a[7]);
                refFlags.d = 1'b0;
            end
            4'h2, 4'h3, 4'hA: begin
                full = int'(a) - int'(b) - ci;
                low = int'(a & 8'h0F) - int'(b & 8'h0F) - ci;
                r = full[7:0];
                refFlags.c = full < 0;
                refFlags.h = low < 0;
                refFlags.v = (a[7] != b[7]) && (r[7] != a[7]);
                refFlags.d = 1'b1;
            end
            4'h8: begin
                r = a + 8'd1;
                refFlags.v = (a == 8'h7F);
            end
            default: begin
                case (op)
                    4'h4: r = a | b;
                    4'h6: r = ~a & b;
                    4'hB: r = a ^ b;
                    default: r = a & b;
                endcase
                refFlags.v = 1'b0;
            end
        endcase
        refFlags.z = (r == 8'h00);
        refFlags.s = r[7];
        return r;
    endfunction

    function automatic void runReference();
        logic [15:0] pc;
        logic [7:0] op;
        logic [7:0] b2;
        logic [7:0] b3;
        logic [7:0] r;
        expPort2.delete();
        for (int i = 0; i < 128; i++) refRegs[i] = '0;
        refFlags = '0;
        refRp = '0;
        refPort2 = '0;
        expLoop = 16'hFFFF;
        pc = `Z8_RESET_PC;
        for (int step = 0; step < 100000; step++) begin
            op = mem[pc];
            b2 = mem[pc + 1];
            b3 = mem[pc + 2];
            if (op == 8'h8B && b2 == 8'hFE) begin
                expLoop = pc;
                return;
            end
            case (op[3:0])
                4'h1: begin
                    if (op[7:4] == 4'h3) writeReg(8'hFD, b2);
                    pc += (op[7:4] == 4'h3) ? 2 : 1;
                end
                4'h6: begin
                    if (op[7:4] == 4'hE) begin
                        writeReg(b2, b3);
                        pc += 3;
                    end else if (op[7:4] <= 4'h7 || op[7:4] == 4'hA || op[7:4] == 4'hB) begin
                        r = aluStep(op[7:4], readReg(b2), b3);
                        if (!(op[7:4] inside {4'h6, 4'h7, 4'hA})) writeReg(b2, r);
                        pc += 3;
                    end else begin
                        pc += 1;
                    end
                end
                4'hA: begin
                    r = readReg({4'hE, op[7:4]}) - 8'd1;
                    writeReg({4'hE, op[7:4]}, r);
                    pc += 2;
                    if (r != 8'h00) pc += {{8{b2[7]}}, b2};
                end
                4'hB: begin
                    pc += 2;
                    if (condTrue(op[7:4])) pc += {{8{b2[7]}}, b2};
                end
                4'hC: begin
                    writeReg({4'hE, op[7:4]}, b2);
                    pc += 2;
                end
                4'hD: begin
                    pc += 3;
                    if (condTrue(op[7:4])) pc = {b2, b3};
                end
                4'hE: begin
                    r = aluStep(4'h8, readReg({4'hE, op[7:4]}), 8'h00);
                    writeReg({4'hE, op[7:4]}, r);
                    pc += 1;
                end
                default: begin
                    if (op == 8'hCF) refFlags.c = 1'b0;
                    if (op == 8'hDF) refFlags.c = 1'b1;
                    if (op == 8'hEF) refFlags.c = ~refFlags.c;
                    pc += 1;
                end
            endcase
        end
    endfunction

    initial begin
        int cycles;
        int limit;
        logic timedOut;
        void'($urandom(32'h1189));
        rst = 1'b1;
        wbRsp = '0;
        timedOut = 1'b0;
        for (int p = 0; p < numPrograms && !timedOut; p++) begin
            @(posedge clk);
            rst <= 1'b1;
            buildProgram();
            runReference();
            limit = 40 * progLen + 2000;
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            cycles = 0;
            while (!wbReq.cyc && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            if (wbReq.adr !== `Z8_RESET_PC) begin
                $display("mismatch first fetch adr: got %04h, expected %04h",
                         wbReq.adr, `Z8_RESET_PC);
                errors++;
            end
            if (port2 !== 8'h00) begin
                $display("mismatch port2 after reset: got %02h, expected 00", port2);
                errors++;
            end
            while (!loopSeen && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            if (!loopSeen) begin
                $display("timeout: program %0d never reached its final loop", p);
                errors++;
                timedOut = 1'b1;
            end else begin
                if (loopAddr !== expLoop) begin
                    $display("mismatch loopAddr: got %04h, expected %04h", loopAddr, expLoop);
                    errors++;
                end
                if (seenCount != expPort2.size()) begin
                    $display("program %0d saw %0d port2 changes, expected %0d",
                             p, seenCount, expPort2.size());
                    errors++;
                end
            end
        end
        errors += z8Core_inst.busChecks.failCount;
        $display("%0d errors over %0d programs", errors, numPrograms);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* z8Core_asserts.sv */
`default_nettype none
`include "z8_consts.svh"

module z8CoreAsserts (
    input wire logic clk,
    input wire logic rst,
    input wire z8Pkg::wbReqT wbReq,
    input wire z8Pkg::wbRspT wbRsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import z8Pkg::*;

    // read by the testbench at the end of the run
    int failCount = 0;

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst)
        wbReq.stb |-> wbReq.cyc)
        else begin
            $error("stb high without cyc");
            failCount++;
        end

    // request held until the slave answers
    holdUntilAck: assert property (@(posedge clk) disable iff (rst)
        wbReq.stb && !wbRsp.ack |=> wbReq.stb && $stable(wbReq.adr))
        else begin
            $error("stb or adr changed before ack");
            failCount++;
        end

    idleAfterReset: assert property (@(posedge clk)
        $past(rst) |-> !wbReq.cyc)
        else begin
            $error("cyc high in the cycle after reset");
            failCount++;
        end

    idleAfterAck: assert property (@(posedge clk) disable iff (rst)
        wbReq.cyc && wbRsp.ack |=> !wbReq.cyc)
        else begin
            $error("cyc still high in the cycle after ack");
            failCount++;
        end

endmodule

bind z8Core z8CoreAsserts busChecks (.clk, .rst, .wbReq, .wbRsp);

`default_nettype wire

/* z8Core.sv */
`default_nettype none
`include "z8_consts.svh"

module z8Core (
    input  wire logic clk,
    input  wire logic rst,
    output z8Pkg::wbReqT wbReq,
    input  wire z8Pkg::wbRspT wbRsp,
    output logic [`Z8_DATA_W-1:0] port2
);
    import z8Pkg::*;

    logic [`Z8_DATA_W-1:0] opcode;
    decodedT decoded;
    logic [`Z8_DATA_W-1:0] regReadAddr;
    logic [`Z8_DATA_W-1:0] regReadData;
    logic [`Z8_DATA_W-1:0] regWriteAddr;
    logic [`Z8_DATA_W-1:0] regWriteData;
    logic regWrite;
    logic flagsWrite;
    logic [1:0] carryCtl;
    flagsT newFlags;
    flagsT flags;
    aluOp aluOpSel;
    logic [`Z8_DATA_W-1:0] aluA;
    logic [`Z8_DATA_W-1:0] aluB;
    logic [`Z8_DATA_W-1:0] aluResult;

    z8Sequencer seqInst (.*);

    z8Decoder decInst (.*);

    z8Alu aluInst (
        .op(aluOpSel),
        .a(aluA),
        .b(aluB),
        .flagsIn(flags),
        .result(aluResult),
        .flagsOut(newFlags)
    );

    z8RegFile regFileInst (
        .clk,
        .rst,
        .readAddr(regReadAddr),
        .readData(regReadData),
        .writeAddr(regWriteAddr),
        .writeData(regWriteData),
        .write(regWrite),
        .flagsWrite,
        .carryCtl,
        .newFlags,
        .flags,
        .port2
    );

endmodule

`default_nettype wire

/* z8Sequencer.sv */
`default_nettype none
`include "z8_consts.svh"

module z8Sequencer (
    input  wire logic clk,
    input  wire logic rst,
    output z8Pkg::wbReqT wbReq,
    input  wire z8Pkg::wbRspT wbRsp,
    output logic [`Z8_DATA_W-1:0] opcode,
    input  wire z8Pkg::decodedT decoded,
    output logic [`Z8_DATA_W-1:0] regReadAddr,
    input  wire logic [`Z8_DATA_W-1:0] regReadData,
    output logic [`Z8_DATA_W-1:0] regWriteAddr,
    output logic [`Z8_DATA_W-1:0] regWriteData,
    output logic regWrite,
    output logic flagsWrite,
    output logic [1:0] carryCtl,
    input  wire z8Pkg::flagsT newFlags,
    input  wire z8Pkg::flagsT flags,
    output z8Pkg::aluOp aluOpSel,
    output logic [`Z8_DATA_W-1:0] aluA,
    output logic [`Z8_DATA_W-1:0] aluB,
    input  wire logic [`Z8_DATA_W-1:0] aluResult
);
    import z8Pkg::*;

    seqState state;
    seqState nextFetch;
    logic cyc;
    logic [`Z8_ADDR_W-1:0] pc;
    logic [`Z8_ADDR_W-1:0] relTarget;
    logic [`Z8_DATA_W-1:0] opReg;
    logic [`Z8_DATA_W-1:0] byte2;
    logic [`Z8_DATA_W-1:0] byte3;
    logic [`Z8_DATA_W-1:0] opA;
    logic [`Z8_DATA_W-1:0] target;
    logic [`Z8_DATA_W-1:0] djnzCount;
    logic condMet;
    logic takeBranch;
    logic writesResult;

    assign wbReq = '{cyc: cyc, stb: cyc, adr: pc};

    // decode straight off the bus while the opcode arrives
    assign opcode = (state == fetchOp) ? wbRsp.dat : opReg;

    always_comb begin
        case (decoded.cond[2:0])
            3'd0: condMet = 1'b0;
            3'd1: condMet = flags.s ^ flags.v;
            3'd2: condMet = (flags.s ^ flags.v) | flags.z;
            3'd3: condMet = flags.c | flags.z;
            3'd4: condMet = flags.v;
            3'd5: condMet = flags.s;
            3'd6: condMet = flags.z;
            default: condMet = flags.c;
        endcase
    end
    assign takeBranch = condMet ^ decoded.cond[3];

    always_comb begin
        case (decoded.cls)
            aluImm, ldRegImm: target = byte2;
            srp:              target = `Z8_REG_RP;
            default:          target = {`Z8_WORK_PREFIX, opReg[7:4]};
        endcase
    end

    always_comb begin
        case (state)
            fetchOp: nextFetch = (decoded.len == 2'd1) ? execute : fetch2;
            fetch2:  nextFetch = (decoded.len == 2'd3) ? fetch3 : execute;
            default: nextFetch = execute;
        endcase
    end

    // pc already points past the instruction
    assign relTarget = pc + {{(`Z8_ADDR_W - `Z8_DATA_W){byte2[7]}}, byte2};
    assign djnzCount = opA - 1'b1;
    assign writesResult = !(decoded.op inside {opCp, opTcm, opTm});

    assign regReadAddr = target;
    assign regWriteAddr = target;
    assign regWriteData = (state == branch) ? djnzCount : aluResult;
    assign aluOpSel = decoded.op;
    assign aluA = (state == aluWrite) ? opA : ((decoded.len == 2'd3) ? byte3 : byte2);
    assign aluB = byte3;
    // no flags write when the ALU leaves them as they are
    assign flagsWrite = (state == aluWrite) && (newFlags != flags);

    always_comb begin
        case (state)
            execute:  regWrite = decoded.cls inside {ldWorkImm, ldRegImm, srp};
            aluWrite: regWrite = writesResult;
            branch:   regWrite = 1'b1;
            default:  regWrite = 1'b0;
        endcase
    end

    always_comb begin
        carryCtl = `Z8_CARRY_NONE;
        if (state == execute) begin
            case (decoded.cls)
                setCarry:        carryCtl = `Z8_CARRY_SET;
                clearCarry:      carryCtl = `Z8_CARRY_CLEAR;
                complementCarry: carryCtl = `Z8_CARRY_FLIP;
                default:         carryCtl = `Z8_CARRY_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetchOp;
            pc <= `Z8_RESET_PC;
            cyc <= 1'b0;
        end else begin
            case (state)
                fetchOp, fetch2, fetch3: begin
                    // one idle cycle before each request
                    if (!cyc) begin
                        cyc <= 1'b1;
                    end else if (wbRsp.ack) begin
                        cyc <= 1'b0;
                        pc <= pc + 1'b1;
                        state <= nextFetch;
                    end
                end
                execute: begin
                    state <= fetchOp;
                    case (decoded.cls)
                        aluImm, incWork: state <= aluWrite;
                        djnz:            state <= branch;
                        jumpRel: begin
                            if (takeBranch) begin
                                pc <= relTarget;
                            end
                        end
                        jumpDirect: begin
                            if (takeBranch) begin
                                pc <= {byte2, byte3};
                            end
                        end
                        default: ;
                    endcase
                end
                branch: begin
                    if (djnzCount != '0) begin
                        pc <= relTarget;
                    end
                    state <= fetchOp;
                end
                default: state <= fetchOp;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && wbRsp.ack) begin
            case (state)
                fetchOp: opReg <= wbRsp.dat;
                fetch2:  byte2 <= wbRsp.dat;
                default: byte3 <= wbRsp.dat;
            endcase
        end
        // operand for the writeback cycle
        if (state == execute) begin
            opA <= regReadData;
        end
    end

endmodule

`default_nettype wire

/* z8Decoder.sv */
`default_nettype none
`include "z8_consts.svh"

module z8Decoder (
    input  wire logic [`Z8_DATA_W-1:0] opcode,
    output z8Pkg::decodedT decoded
);
    import z8Pkg::*;

    logic [3:0] hi;
    logic [3:0] lo;

    assign hi = opcode[7:4];
    assign lo = opcode[3:0];

    always_comb begin
        // anything not listed below runs as a one-byte nop
        decoded.cls = illegal;
        decoded.op = opLd;
        decoded.len = 2'd1;
        decoded.cond = hi;
        case (lo)
            4'h1: begin
                if (hi == 4'h3) begin
                    decoded.cls = srp;
                    decoded.len = 2'd2;
                end
            end
            4'h6: begin
                if (hi == 4'hE) begin
                    decoded.cls = ldRegImm;
                    decoded.len = 2'd3;
                end else if (hi <= 4'h7 || hi == 4'hA || hi == 4'hB) begin
                    decoded.cls = aluImm;
                    decoded.op = aluOp'(hi);
                    decoded.len = 2'd3;
                end
            end
            4'hA: begin
                decoded.cls = djnz;
                decoded.len = 2'd2;
            end
            4'hB: begin
                decoded.cls = jumpRel;
                decoded.len = 2'd2;
            end
            4'hC: begin
                decoded.cls = ldWorkImm;
                decoded.len = 2'd2;
            end
            4'hD: begin
                decoded.cls = jumpDirect;
                decoded.len = 2'd3;
            end
            4'hE: begin
                decoded.cls = incWork;
                decoded.op = opInc;
            end
            4'hF: begin
                case (hi)
                    4'hC:    decoded.cls = clearCarry;
                    4'hD:    decoded.cls = setCarry;
                    4'hE:    decoded.cls = complementCarry;
                    4'hF:    decoded.cls = nop;
                    default: decoded.cls = illegal;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* z8RegFile.sv */
`default_nettype none
`include "z8_consts.svh"

module z8RegFile (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic [`Z8_DATA_W-1:0] readAddr,
    output logic [`Z8_DATA_W-1:0] readData,
    input  wire logic [`Z8_DATA_W-1:0] writeAddr,
    input  wire logic [`Z8_DATA_W-1:0] writeData,
    input  wire logic write,
    input  wire logic flagsWrite,
    input  wire logic [1:0] carryCtl,
    input  wire z8Pkg::flagsT newFlags,
    output z8Pkg::flagsT flags,
    output logic [`Z8_DATA_W-1:0] port2
);
    import z8Pkg::*;

    localparam int idxW = $clog2(`Z8_REG_DEPTH);

    logic [`Z8_DATA_W-1:0] regs [`Z8_REG_DEPTH];
    logic [3:0] rp;
    logic [`Z8_DATA_W-1:0] rdAddr;
    logic [`Z8_DATA_W-1:0] wrAddr;

    // En selects working register n of the bank that RP points at
    function automatic logic [`Z8_DATA_W-1:0] translate(
        input logic [`Z8_DATA_W-1:0] addr,
        input logic [3:0] bank
    );
        if (addr[7:4] == `Z8_WORK_PREFIX) begin
            return {bank, addr[3:0]};
        end
        return addr;
    endfunction

    assign rdAddr = translate(readAddr, rp);
    assign wrAddr = translate(writeAddr, rp);

    always_comb begin
        if (rdAddr < `Z8_REG_DEPTH) begin
            readData = regs[rdAddr[idxW-1:0]];
        end else if (rdAddr == `Z8_REG_FLAGS) begin
            readData = flags;
        end else if (rdAddr == `Z8_REG_RP) begin
            readData = {rp, 4'h0};
        end else begin
            readData = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `Z8_REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
            rp <= '0;
            port2 <= '0;
        end else begin
            if (flagsWrite) begin
                flags <= newFlags;
            end
            case (carryCtl)
                `Z8_CARRY_SET:   flags.c <= 1'b1;
                `Z8_CARRY_CLEAR: flags.c <= 1'b0;
                `Z8_CARRY_FLIP:  flags.c <= ~flags.c;
                default: ;
            endcase
            // register write comes last so it beats the ALU flags
            if (write) begin
                if (wrAddr < `Z8_REG_DEPTH) begin
                    regs[wrAddr[idxW-1:0]] <= writeData;
                end else if (wrAddr == `Z8_REG_FLAGS) begin
                    flags <= flagsT'(writeData);
                end else if (wrAddr == `Z8_REG_RP) begin
                    rp <= writeData[7:4];
                end
                if (wrAddr == `Z8_REG_PORT2) begin
                    port2 <= writeData;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* z8Alu.sv */
`default_nettype none
`include "z8_consts.svh"

module z8Alu (
    input  wire z8Pkg::aluOp op,
    input  wire logic [`Z8_DATA_W-1:0] a,
    input  wire logic [`Z8_DATA_W-1:0] b,
    input  wire z8Pkg::flagsT flagsIn,
    output logic [`Z8_DATA_W-1:0] result,
    output z8Pkg::flagsT flagsOut
);
    import z8Pkg::*;

    localparam int msb = `Z8_DATA_W - 1;

    logic carryIn;
    logic [`Z8_DATA_W:0] sum;
    logic [`Z8_DATA_W:0] diff;
    logic [4:0] sumLow;
    logic [4:0] diffLow;

    // carry doubles as borrow for sbc
    assign carryIn = (op == opAdc || op == opSbc) ? flagsIn.c : 1'b0;
    assign sum = {1'b0, a} + {1'b0, b} + carryIn;
    assign diff = {1'b0, a} - {1'b0, b} - carryIn;
    assign sumLow = {1'b0, a[3:0]} + {1'b0, b[3:0]} + carryIn;
    assign diffLow = {1'b0, a[3:0]} - {1'b0, b[3:0]} - carryIn;

    always_comb begin
        result = a;
        flagsOut = flagsIn;
        case (op)
            opAdd, opAdc: begin
                result = sum[msb:0];
                flagsOut.c = sum[msb+1];
                flagsOut.v = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
                flagsOut.h = sumLow[4];
                flagsOut.d = 1'b0;
            end
            opSub, opSbc, opCp: begin
                result = diff[msb:0];
                flagsOut.c = diff[msb+1];
                flagsOut.v = (a[msb] != b[msb]) && (diff[msb] != a[msb]);
                flagsOut.h = diffLow[4];
                flagsOut.d = 1'b1;
            end
            opOr, opAnd, opTcm, opTm, opXor: begin
                case (op)
                    opOr:    result = a | b;
                    opXor:   result = a ^ b;
                    opTcm:   result = ~a & b;
                    default: result = a & b;
                endcase
                flagsOut.v = 1'b0;
            end
            opInc: begin
                result = a + 1'b1;
                flagsOut.v = (a == {1'b0, {msb{1'b1}}});
            end
            default: begin
                result = a;
            end
        endcase
        // ld moves data and leaves every flag alone
        if (op != opLd) begin
            flagsOut.z = (result == '0);
            flagsOut.s = result[msb];
        end
    end

endmodule

`default_nettype wire

/* z8Pkg.sv */
`default_nettype none
`include "z8_consts.svh"

package z8Pkg;

    // two-operand values follow the opcode high nibble
    typedef enum logic [3:0] {
        opAdd = 4'h0,
        opAdc = 4'h1,
        opSub = 4'h2,
        opSbc = 4'h3,
        opOr  = 4'h4,
        opAnd = 4'h5,
        opTcm = 4'h6,
        opTm  = 4'h7,
        opInc = 4'h8,
        opLd  = 4'h9,
        opCp  = 4'hA,
        opXor = 4'hB
    } aluOp;

    typedef enum logic [3:0] {
        ldWorkImm,
        ldRegImm,
        aluImm,
        incWork,
        srp,
        djnz,
        jumpRel,
        jumpDirect,
        setCarry,
        clearCarry,
        complementCarry,
        nop,
        illegal
    } instrClass;

    typedef enum logic [2:0] {
        fetchOp,
        fetch2,
        fetch3,
        execute,
        aluWrite,
        branch
    } seqState;

    // FLAGS register layout, carry in bit 7
    typedef struct packed {
        logic c;
        logic z;
        logic s;
        logic v;
        logic d;
        logic h;
        logic [1:0] unused;
    } flagsT;

    typedef struct packed {
        instrClass cls;
        aluOp op;
        logic [1:0] len;
        logic [3:0] cond;
    } decodedT;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic [`Z8_ADDR_W-1:0] adr;
    } wbReqT;

    typedef struct packed {
        logic ack;
        logic [`Z8_DATA_W-1:0] dat;
    } wbRspT;

endpackage

`default_nettype wire

/* z8_consts.svh */
`ifndef Z8_CONSTS_SVH
`define Z8_CONSTS_SVH

// bus widths
`define Z8_ADDR_W 16
`define Z8_DATA_W 8

// first opcode fetch after reset
`define Z8_RESET_PC 16'h000C

// register file
`define Z8_REG_DEPTH 128
`define Z8_REG_PORT2 8'h02
`define Z8_REG_FLAGS 8'hFC
`define Z8_REG_RP 8'hFD

// high nibble of a register byte that names a working register
`define Z8_WORK_PREFIX 4'hE

// carry control requests from the sequencer
`define Z8_CARRY_NONE 2'b00
`define Z8_CARRY_SET 2'b01
`define Z8_CARRY_CLEAR 2'b10
`define Z8_CARRY_FLIP 2'b11

`endif
